/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wall -Wno-fatal
TOP       ?= mux_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Test failures found

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/mux_chk.sv */
// concurrent checks on the arbiter handshake, bound into every slot_arbiter
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module mux_chk (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  downloading,
    input logic [`NUM_SLOTS-1:0] grant,
    input logic [`NUM_SLOTS-1:0] done,
    input logic                  sdram_req,
    input logic                  data_rdy
);

    int fail_count = 0;

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant))
    else begin
        $error("grant is not one-hot");
        fail_count++;
    end

    // done closes the controller access of the slot that held the grant
    a_done_granted: assert property (@(posedge clk) disable iff (!rst_n)
        (|done) |-> ($onehot(done) && $past(data_rdy) && (done == $past(grant))))
    else begin
        $error("done without a finished granted access");
        fail_count++;
    end

    a_no_req_download: assert property (@(posedge clk) disable iff (!rst_n)
        downloading |=> !sdram_req)
    else begin
        $error("sdram_req during download");
        fail_count++;
    end

endmodule

bind slot_arbiter mux_chk u_chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .downloading (downloading),
    .grant       (grant),
    .done        (done),
    .sdram_req   (sdram_req),
    .data_rdy    (data_rdy)
);

`default_nettype wire

/* bench/mux_monitor.sv */
// watches the mux outputs and SDRAM traffic, compares against values handed in by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module mux_monitor
    import sdram_pkg::*;
(
    input  logic       clk,
    input  logic       sdram_req,
    input  sdram_cmd_t sdram_cmd
);

    int                   req_count;
    int                   test_errors;
    int                   passed;
    int                   failed;
    logic                 req_d = 1'b0;
    logic [`SDRAM_AW-1:0] exp_addrs[$];
    logic [`SDRAM_AW-1:0] seen_addrs[$];

    // count rising edges of sdram_req and log the command address
    always @(posedge clk) begin
        req_d <= sdram_req;
        if (sdram_req && !req_d) begin
            req_count++;
            seen_addrs.push_back(sdram_cmd.addr);
        end
    end

    task automatic start_test();
        req_count   = 0;
        test_errors = 0;
        exp_addrs.delete();
        seen_addrs.delete();
    endtask

    task automatic expect_addr(input logic [`SDRAM_AW-1:0] a);
        exp_addrs.push_back(a);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic finish_test(input int id, input string kind, input int exp_reqs);
        check_value("sdram_req rises", req_count, exp_reqs);
        if (exp_addrs.size() > 0) begin
            if (seen_addrs.size() != exp_addrs.size()) begin
                $display("controller saw %0d commands, %0d were expected",
                         seen_addrs.size(), exp_addrs.size());
                test_errors++;
            end else begin
                foreach (exp_addrs[i]) begin
                    check_value("sdram_cmd.addr", seen_addrs[i], exp_addrs[i]);
                end
            end
        end
        if (test_errors == 0) begin
            passed++;
            $display("test %0d %s: pass", id, kind);
        end else begin
            failed++;
            $display("test %0d %s: FAIL (%0d errors)", id, kind, test_errors);
        end
    endtask

endmodule

`default_nettype wire

/* bench/mux_tb.sv */
// testbench top for the SDRAM mux, replays bench/mux_trace.txt against the DUT
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module mux_tb
    import mux_pkg::*;
    import sdram_pkg::*;
;

    logic                             clk;
    logic                             rst_n;
    logic                             vblank;
    logic                             downloading;
    rw_slot_in_t                      rw_in;
    logic [15:0]                      rw_dout;
    logic                             rw_ok;
    rd_slot_in_t [`NUM_RD_SLOTS-1:0]  rd_in;
    logic [`NUM_RD_SLOTS-1:0][15:0]   rd_dout;
    logic [`NUM_RD_SLOTS-1:0]         rd_ok;
    logic                             sdram_req;
    sdram_cmd_t                       sdram_cmd;
    logic                             sdram_ack;
    logic                             data_rdy;
    logic [31:0]                      data_read;
    logic                             refresh_en;
    logic                             ready;

    logic [31:0] kind_q[$];
    logic [31:0] slot_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] off_q[$];
    logic [31:0] data_q[$];
    logic [31:0] mask_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] reqs_q[$];
    logic        trace_loaded = 1'b0;
    logic [31:0] staged_exp [`NUM_SLOTS];
    logic [`NUM_SLOTS-1:0] staged;

    sdram_mux DUT (
        .clk(clk), .rst_n(rst_n), .vblank(vblank), .downloading(downloading),
        .rw_in(rw_in), .rw_dout(rw_dout), .rw_ok(rw_ok),
        .rd_in(rd_in), .rd_dout(rd_dout), .rd_ok(rd_ok),
        .sdram_req(sdram_req), .sdram_cmd(sdram_cmd), .sdram_ack(sdram_ack),
        .data_rdy(data_rdy), .data_read(data_read),
        .refresh_en(refresh_en), .ready(ready)
    );

    sdram_model u_mem (
        .clk(clk), .rst_n(rst_n), .sdram_req(sdram_req), .sdram_cmd(sdram_cmd),
        .sdram_ack(sdram_ack), .data_rdy(data_rdy), .data_read(data_read)
    );

    mux_monitor mon (.clk(clk), .sdram_req(sdram_req), .sdram_cmd(sdram_cmd));

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic set_slot(input int slot, input logic cs, input logic wr,
                            input logic [31:0] addr, input logic [31:0] off,
                            input logic [31:0] din, input logic [31:0] mask);
        if (slot == 0) begin
            rw_in.cs     = cs;
            rw_in.wr     = wr;
            rw_in.addr   = addr[`SLOT_AW-1:0];
            rw_in.offset = off[`SDRAM_AW-1:0];
            rw_in.din    = din[15:0];
            rw_in.wrmask = mask[1:0];
        end else begin
            rd_in[slot-1].cs     = cs;
            rd_in[slot-1].addr   = addr[`SLOT_AW-1:0];
            rd_in[slot-1].offset = off[`SDRAM_AW-1:0];
        end
    endtask

    function automatic logic slot_ok(input int slot);
        return (slot == 0) ? rw_ok : rd_ok[slot-1];
    endfunction

    function automatic logic [15:0] slot_dout(input int slot);
        return (slot == 0) ? rw_dout : rd_dout[slot-1];
    endfunction

    function automatic string kind_name(input logic [31:0] kind);
        case (kind)
            0: return "read";
            1: return "write";
            3: return "priority";
            4: return "refresh";
            default: return "unknown";
        endcase
    endfunction

    task automatic load_trace();
        int          fd;
        int          rc;
        string       line;
        logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7;
        fd = $fopen("bench/mux_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open trace file bench/mux_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                rc = $fgets(line, fd);
                if (rc != 0 && line.len() > 1 && line[0] != "#") begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h",
                                 f0, f1, f2, f3, f4, f5, f6, f7);
                    if (rc == 8) begin
                        kind_q.push_back(f0);
                        slot_q.push_back(f1);
                        addr_q.push_back(f2);
                        off_q.push_back(f3);
                        data_q.push_back(f4);
                        mask_q.push_back(f5);
                        exp_q.push_back(f6);
                        reqs_q.push_back(f7);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_access(input int slot, input logic wr, input logic [31:0] addr,
                              input logic [31:0] off, input logic [31:0] din,
                              input logic [31:0] mask, input logic [31:0] exp);
        set_slot(slot, 1'b1, wr, addr, off, din, mask);
        tick();
        while (!slot_ok(slot)) begin
            tick();
        end
        if (!wr) begin
            mon.check_value("dout", 32'(slot_dout(slot)), exp);
        end
        set_slot(slot, 1'b0, 1'b0, addr, off, din, mask);
        tick();
    endtask

    // all staged slots already hold cs, wait until each has answered
    task automatic run_staged();
        logic [`NUM_SLOTS-1:0] seen;
        seen = '0;
        while (seen != staged) begin
            tick();
            for (int s = 0; s < `NUM_SLOTS; s++) begin
                if (staged[s] && !seen[s] && slot_ok(s)) begin
                    mon.check_value("dout", 32'(slot_dout(s)), staged_exp[s]);
                    set_slot(s, 1'b0, 1'b0, 0, 0, 0, 3);
                    seen[s] = 1'b1;
                end
            end
        end
        staged = '0;
        tick();
    endtask

    task automatic run_refresh(input logic [31:0] ready_dly);
        int n;
        vblank = 1'b1;
        tick();
        tick();
        mon.check_value("refresh_en", 32'(refresh_en), 1);
        vblank = 1'b0;
        tick();
        tick();
        mon.check_value("refresh_en", 32'(refresh_en), 0);
        downloading = 1'b1;
        tick();
        tick();
        mon.check_value("refresh_en", 32'(refresh_en), 1);
        mon.check_value("ready", 32'(ready), 0);
        downloading = 1'b0;
        n = 0;
        do begin
            tick();
            n++;
        end while (!ready);
        // first edge after the drop is the first inactive clock
        mon.check_value("ready delay", n - 1, ready_dly);
    endtask

    initial begin
        rst_n       = 1'b0;
        vblank      = 1'b0;
        downloading = 1'b0;
        rw_in       = '0;
        rd_in       = '0;
        staged      = '0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        while (!ready) begin
            tick();
        end
        foreach (kind_q[i]) begin
            if (kind_q[i] == 2) begin
                if (staged == '0) begin
                    mon.start_test();
                end
                set_slot(slot_q[i], 1'b1, 1'b0, addr_q[i], off_q[i], 0, 3);
                staged[slot_q[i]]     = 1'b1;
                staged_exp[slot_q[i]] = exp_q[i];
                mon.expect_addr(off_q[i][`SDRAM_AW-1:0] + `SDRAM_AW'(addr_q[i]));
            end else begin
                if (kind_q[i] != 3) begin
                    mon.start_test();
                end
                case (kind_q[i])
                    0: run_access(slot_q[i], 1'b0, addr_q[i], off_q[i], 0, 3, exp_q[i]);
                    1: run_access(slot_q[i], 1'b1, addr_q[i], off_q[i], data_q[i],
                                  mask_q[i], 0);
                    3: run_staged();
                    default: run_refresh(data_q[i]);
                endcase
                mon.finish_test(i, kind_name(kind_q[i]), reqs_q[i]);
            end
        end
        $display("tests passed: %0d, tests failed: %0d", mon.passed, mon.failed);
        if (mon.failed == 0 && mon.passed > 0 && DUT.u_arb.u_chk.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        wait (trace_loaded);
        repeat (kind_q.size() * 40 + 100) @(posedge clk);
        $display("watchdog expired before the trace finished");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mux_trace.txt */
# kind slot addr offset data mask expected reqs, all hex
# kind: 0 read, 1 write, 2 stage slot, 3 launch staged, 4 refresh/download (data = ready delay)
0 1 00100 000000 0000 3 5b5a 1
0 1 00101 000000 0000 3 5b5b 0
0 2 00203 010000 0000 3 5859 1
0 2 00202 010000 0000 3 5858 0
0 3 12345 001000 0000 3 691f 1
0 3 12344 001000 0000 3 691e 0
0 0 00400 000000 0000 3 5e5a 1
1 0 00400 000000 a5c3 1 0000 1
0 0 00400 000000 0000 3 a55a 1
1 0 00401 000000 1234 2 0000 1
0 0 00401 000000 0000 3 5e34 1
2 0 00800 000000 0000 3 525a 0
2 1 00900 000000 0000 3 535a 0
2 2 00a01 100000 0000 3 505b 0
2 3 00b03 200000 0000 3 5159 0
3 0 00000 000000 0000 3 0000 4
4 0 00000 000000 0004 3 0000 0

/* bench/sdram_model.sv */
// behavioral SDRAM controller for the mux testbench, fixed ack and data latency
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module sdram_model
    import sdram_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        sdram_req,
    input  sdram_cmd_t  sdram_cmd,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read
);

    // only written halfwords are stored, the rest follow the fill pattern
    logic [15:0] written [int];
    sdram_cmd_t  cmd;
    logic        busy;
    int          phase;

    function automatic logic [15:0] read_half(input logic [`SDRAM_AW-1:0] a);
        if (written.exists(int'(a))) begin
            return written[int'(a)];
        end
        return a[15:0] ^ 16'h5a5a;
    endfunction

    function automatic logic [15:0] merge(input logic [15:0] old, input logic [15:0] wdata,
                                          input logic [1:0] mask);
        logic [15:0] res;
        res[15:8] = mask[1] ? old[15:8] : wdata[15:8];
        res[7:0]  = mask[0] ? old[7:0] : wdata[7:0];
        return res;
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            phase     <= 0;
        end else if (!busy) begin
            if (sdram_req) begin
                busy  <= 1'b1;
                cmd   <= sdram_cmd;
                phase <= 0;
            end
        end else begin
            phase <= phase + 1;
            case (phase)
                0: sdram_ack <= 1'b1;
                1: sdram_ack <= 1'b0;
                3: begin
                    data_rdy  <= 1'b1;
                    data_read <= {read_half({cmd.addr[`SDRAM_AW-1:1], 1'b1}),
                                  read_half({cmd.addr[`SDRAM_AW-1:1], 1'b0})};
                    if (cmd.op == OP_WRITE) begin
                        written[int'(cmd.addr)] = merge(read_half(cmd.addr), cmd.wdata,
                                                        cmd.wrmask);
                    end
                end
                4: begin
                    data_rdy <= 1'b0;
                    busy     <= 1'b0;
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/sdram_pkg.sv
src/mux_pkg.sv
src/rd_slot.sv
src/rw_slot.sv
src/slot_arbiter.sv
src/sdram_mux.sv
bench/sdram_model.sv
bench/mux_monitor.sv
bench/mux_chk.sv
bench/mux_tb.sv

/* src/mux_pkg.sv */
// slot-side types and helpers of the SDRAM mux, shared by the slots, the arbiter and the top
`default_nettype none

`include "mux_settings.svh"

package mux_pkg;
    import sdram_pkg::*;

    typedef struct packed {
        logic                 cs;
        logic [`SLOT_AW-1:0]  addr;
        logic [`SDRAM_AW-1:0] offset;
    } rd_slot_in_t;

    typedef struct packed {
        logic                 cs;
        logic                 wr;
        logic [`SLOT_AW-1:0]  addr;
        logic [`SDRAM_AW-1:0] offset;
        logic [15:0]          din;
        // active low, a set bit keeps its byte
        logic [1:0]           wrmask;
    } rw_slot_in_t;

    typedef struct packed {
        logic                 req;
        logic [`SDRAM_AW-1:0] addr;
        sdram_op_e            op;
        logic [15:0]          wdata;
        logic [1:0]           wrmask;
    } slot_req_t;

    localparam slot_req_t SLOT_REQ_IDLE = '{
        req: 1'b0, addr: '0, op: OP_READ, wdata: '0, wrmask: 2'b11
    };

    // even halfword sits in the low half of the word
    function automatic logic [15:0] sel_half(input logic [31:0] word, input logic a0);
        return a0 ? word[31:16] : word[15:0];
    endfunction

endpackage

`default_nettype wire

/* src/mux_settings.svh */
// build-time sizes for the SDRAM mux, included by every package and module that needs them
`ifndef MUX_SETTINGS_SVH
`define MUX_SETTINGS_SVH

// read-only slots, 1 to 8
`define NUM_RD_SLOTS 3
// slot 0 is the read/write slot
`define NUM_SLOTS (`NUM_RD_SLOTS + 1)

// halfword address widths
`define SDRAM_AW 22
`define SLOT_AW 20

// cycles from reset or download end to ready
`define READY_DLY 4

`endif

/* src/rd_slot.sv */
// read-only client slot with a one-word cache, instantiated once per read port of the mux
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module rd_slot
    import mux_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  rd_slot_in_t slot_in,
    input  logic        grant,
    input  logic        done,
    input  logic [31:0] data_read,
    output slot_req_t   slot_req,
    output logic [15:0] dout,
    output logic        ok
);

    logic [`SDRAM_AW-1:0] sdram_addr;
    logic [`SDRAM_AW-2:0] word_tag;
    logic [`SDRAM_AW-2:0] cache_tag;
    logic [31:0]          cache_word;
    logic                 cache_valid;
    logic                 pending;
    logic                 start;
    logic                 hit;

    assign sdram_addr = slot_in.offset + `SDRAM_AW'(slot_in.addr);
    assign word_tag   = sdram_addr[`SDRAM_AW-1:1];
    assign hit        = cache_valid && (cache_tag == word_tag);
    // ok blocks the cycle where the master still holds the old request
    assign start      = slot_in.cs && !ok && !pending;

    always_comb begin
        slot_req      = SLOT_REQ_IDLE;
        slot_req.req  = pending && !grant;
        slot_req.addr = sdram_addr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending     <= 1'b0;
            cache_valid <= 1'b0;
            ok          <= 1'b0;
        end else begin
            ok <= 1'b0;
            if (done) begin
                pending     <= 1'b0;
                cache_valid <= 1'b1;
                ok          <= 1'b1;
            end else if (start) begin
                if (hit) begin
                    ok <= 1'b1;
                end else begin
                    pending <= 1'b1;
                end
            end
        end
    end

    // cache fill and read data
    always_ff @(posedge clk) begin
        if (done) begin
            cache_word <= data_read;
            cache_tag  <= word_tag;
            dout       <= sel_half(data_read, sdram_addr[0]);
        end else if (start && hit) begin
            dout <= sel_half(cache_word, sdram_addr[0]);
        end
    end

endmodule

`default_nettype wire

/* src/rw_slot.sv */
// read/write client slot (slot 0) of the mux, every access goes to the SDRAM
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module rw_slot
    import mux_pkg::*;
    import sdram_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  rw_slot_in_t slot_in,
    input  logic        grant,
    input  logic        done,
    input  logic [31:0] data_read,
    output slot_req_t   slot_req,
    output logic [15:0] dout,
    output logic        ok
);

    logic [`SDRAM_AW-1:0] sdram_addr;
    logic                 pending;

    assign sdram_addr = slot_in.offset + `SDRAM_AW'(slot_in.addr);

    // grant stays up until the arbiter is back in idle, so no reissue
    always_comb begin
        slot_req.req    = pending && !grant;
        slot_req.addr   = sdram_addr;
        slot_req.op     = slot_in.wr ? OP_WRITE : OP_READ;
        slot_req.wdata  = slot_in.din;
        slot_req.wrmask = slot_in.wr ? slot_in.wrmask : 2'b11;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
            ok      <= 1'b0;
        end else begin
            ok <= 1'b0;
            if (done) begin
                pending <= 1'b0;
                ok      <= 1'b1;
            end else if (slot_in.cs && !ok && !pending) begin
                pending <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (done && !slot_in.wr) begin
            dout <= sel_half(data_read, sdram_addr[0]);
        end
    end

endmodule

`default_nettype wire

/* src/sdram_mux.sv */
// top of the SDRAM mux, shares one controller among the R/W slot and the read slots
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module sdram_mux
    import mux_pkg::*;
    import sdram_pkg::*;
(
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              vblank,
    input  logic                              downloading,
    input  rw_slot_in_t                       rw_in,
    output logic [15:0]                       rw_dout,
    output logic                              rw_ok,
    // entry i is slot i+1
    input  rd_slot_in_t [`NUM_RD_SLOTS-1:0]   rd_in,
    output logic [`NUM_RD_SLOTS-1:0][15:0]    rd_dout,
    output logic [`NUM_RD_SLOTS-1:0]          rd_ok,
    output logic                              sdram_req,
    output sdram_cmd_t                        sdram_cmd,
    input  logic                              sdram_ack,
    input  logic                              data_rdy,
    input  logic [31:0]                       data_read,
    output logic                              refresh_en,
    output logic                              ready
);

    slot_req_t [`NUM_SLOTS-1:0] slot_reqs;
    logic [`NUM_SLOTS-1:0]      grant;
    logic [`NUM_SLOTS-1:0]      done;

    rw_slot u_rw (
        .clk       (clk),
        .rst_n     (rst_n),
        .slot_in   (rw_in),
        .grant     (grant[0]),
        .done      (done[0]),
        .data_read (data_read),
        .slot_req  (slot_reqs[0]),
        .dout      (rw_dout),
        .ok        (rw_ok)
    );

    for (genvar i = 0; i < `NUM_RD_SLOTS; i++) begin : g_rd
        rd_slot u_rd (
            .clk       (clk),
            .rst_n     (rst_n),
            .slot_in   (rd_in[i]),
            .grant     (grant[i+1]),
            .done      (done[i+1]),
            .data_read (data_read),
            .slot_req  (slot_reqs[i+1]),
            .dout      (rd_dout[i]),
            .ok        (rd_ok[i])
        );
    end

    slot_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .vblank      (vblank),
        .downloading (downloading),
        .slot_reqs   (slot_reqs),
        .grant       (grant),
        .done        (done),
        .sdram_req   (sdram_req),
        .sdram_cmd   (sdram_cmd),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .refresh_en  (refresh_en),
        .ready       (ready)
    );

endmodule

`default_nettype wire

/* src/sdram_pkg.sv */
// controller-side types of the SDRAM mux, imported by the arbiter, the R/W slot and the top
`default_nettype none

`include "mux_settings.svh"

package sdram_pkg;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } sdram_op_e;

    // command held stable while sdram_req is high
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        sdram_op_e            op;
        logic [15:0]          wdata;
        logic [1:0]           wrmask;
    } sdram_cmd_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_WAIT
    } arb_state_e;

endpackage

`default_nettype wire

/* src/slot_arbiter.sv */
// fixed-priority arbiter of the mux, owns the SDRAM command, refresh enable and ready
`timescale 1ns/1ps
`default_nettype none

`include "mux_settings.svh"

module slot_arbiter
    import mux_pkg::*;
    import sdram_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        vblank,
    input  logic                        downloading,
    input  slot_req_t [`NUM_SLOTS-1:0]  slot_reqs,
    output logic [`NUM_SLOTS-1:0]       grant,
    output logic [`NUM_SLOTS-1:0]       done,
    output logic                        sdram_req,
    output sdram_cmd_t                  sdram_cmd,
    input  logic                        sdram_ack,
    input  logic                        data_rdy,
    output logic                        refresh_en,
    output logic                        ready
);

    localparam int IDX_W   = $clog2(`NUM_SLOTS);
    localparam int READY_W = $clog2(`READY_DLY + 1);

    arb_state_e           state;
    logic [`NUM_SLOTS-1:0] pick;
    logic [IDX_W-1:0]     pick_idx;
    logic [READY_W-1:0]   ready_cnt;
    logic                 data_end;

    // lowest index wins, so scan downwards and let the last match stand
    always_comb begin
        pick     = '0;
        pick_idx = '0;
        for (int i = `NUM_SLOTS - 1; i >= 0; i--) begin
            if (slot_reqs[i].req) begin
                pick     = '0;
                pick[i]  = 1'b1;
                pick_idx = IDX_W'(i);
            end
        end
    end

    // data_rdy only counts once the controller has taken the request
    assign data_end = data_rdy && (!sdram_req || sdram_ack);

    always_ff @(posedge clk) begin
        if (!rst_n || downloading) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            done       <= '0;
            sdram_req  <= 1'b0;
            refresh_en <= 1'b1;
            ready      <= 1'b0;
            ready_cnt  <= '0;
        end else begin
            done       <= '0;
            refresh_en <= 1'b0;
            if (!ready) begin
                if (ready_cnt == READY_W'(`READY_DLY)) begin
                    ready <= 1'b1;
                end else begin
                    ready_cnt <= ready_cnt + 1'b1;
                end
            end
            case (state)
                ARB_IDLE: begin
                    grant <= pick;
                    if (|pick) begin
                        state <= ARB_ISSUE;
                    end else begin
                        refresh_en <= vblank;
                    end
                end
                ARB_ISSUE: begin
                    sdram_req <= 1'b1;
                    state     <= ARB_WAIT;
                end
                ARB_WAIT: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                    end
                    // grant is kept through the done cycle
                    if (data_end) begin
                        done  <= grant;
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && |pick) begin
            sdram_cmd.addr   <= slot_reqs[pick_idx].addr;
            sdram_cmd.op     <= slot_reqs[pick_idx].op;
            sdram_cmd.wdata  <= slot_reqs[pick_idx].wdata;
            sdram_cmd.wrmask <= slot_reqs[pick_idx].wrmask;
        end
    end

endmodule

`default_nettype wire
